// File: enigma.f
+incdir+rtl
+incdir+sim
rtl/enigmaPkg.sv
rtl/letterDecoder.sv
rtl/letterEncoder.sv
rtl/plugBoard.sv
rtl/rotorWheel.sv
rtl/reflector.sv
rtl/enigmaMachine.sv
sim/enigmaTb.sv

// File: rtl/enigmaMachine.sv
// Enigma top level chaining plugboard, three rotors and reflector for one key per cycle
`timescale 1ns/1ps
`default_nettype none

module enigmaMachine (
    input  logic                load,
    input  logic                reset,
    input  logic                keyValid,
    input  logic                setPositions,
    input  enigmaPkg::asciiChar keyChar,
    input  enigmaPkg::rotorPos  startPosition1,
    input  enigmaPkg::rotorPos  startPosition2,
    input  enigmaPkg::rotorPos  startPosition3,
    output logic                outValid,
    output enigmaPkg::asciiChar outChar
);

    enigmaPkg::letterOneHot keyLetter;
    enigmaPkg::letterOneHot plugToRotor1;
    enigmaPkg::letterOneHot rotor1ToRotor2;
    enigmaPkg::letterOneHot rotor2ToRotor3;
    enigmaPkg::letterOneHot rotor3ToReflector;
    enigmaPkg::letterOneHot reflectorToRotor3;
    enigmaPkg::letterOneHot rotor3ToRotor2;
    enigmaPkg::letterOneHot rotor2ToRotor1;
    enigmaPkg::letterOneHot rotor1ToPlug;
    enigmaPkg::letterOneHot cipherLetter;
    enigmaPkg::asciiChar    cipherChar;
    logic                   isLetter;
    logic                   keyAccepted;
    logic                   step1;
    logic                   carry1;
    logic                   carry2;

    // A position load in the same cycle drops the key
    assign keyAccepted = keyValid && !setPositions;
    assign step1       = keyAccepted && isLetter;

    letterDecoder decoder (
        .keyChar  (keyChar),
        .letter   (keyLetter),
        .isLetter (isLetter)
    );

    plugBoard plugs (
        .forwardIn   (keyLetter),
        .backwardIn  (rotor1ToPlug),
        .forwardOut  (plugToRotor1),
        .backwardOut (cipherLetter)
    );

    rotorWheel #(.rotorType(1)) rotor1 (
        .load          (load),
        .reset         (reset),
        .setPositions  (setPositions),
        .stepIn        (step1),
        .startPosition (startPosition1),
        .forwardIn     (plugToRotor1),
        .backwardIn    (rotor2ToRotor1),
        .forwardOut    (rotor1ToRotor2),
        .backwardOut   (rotor1ToPlug),
        .carryOut      (carry1)
    );

    rotorWheel #(.rotorType(2)) rotor2 (
        .load          (load),
        .reset         (reset),
        .setPositions  (setPositions),
        .stepIn        (carry1),
        .startPosition (startPosition2),
        .forwardIn     (rotor1ToRotor2),
        .backwardIn    (rotor3ToRotor2),
        .forwardOut    (rotor2ToRotor3),
        .backwardOut   (rotor2ToRotor1),
        .carryOut      (carry2)
    );

    // Last rotor, its carry has nowhere to go
    rotorWheel #(.rotorType(3)) rotor3 (
        .load          (load),
        .reset         (reset),
        .setPositions  (setPositions),
        .stepIn        (carry2),
        .startPosition (startPosition3),
        .forwardIn     (rotor2ToRotor3),
        .backwardIn    (reflectorToRotor3),
        .forwardOut    (rotor3ToReflector),
        .backwardOut   (rotor3ToRotor2),
        .carryOut      ()
    );

    reflector turnaround (
        .contactsIn  (rotor3ToReflector),
        .contactsOut (reflectorToRotor3)
    );

    letterEncoder encoder (
        .letter      (cipherLetter),
        .encodedChar (cipherChar)
    );

    // Cipher uses the positions from before this edge
    always_ff @(posedge load) begin
        if (reset) begin
            outValid <= 1'b0;
            outChar  <= '0;
        end else begin
            outValid <= keyAccepted;
            if (keyAccepted) begin
                outChar <= isLetter ? cipherChar : keyChar;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/enigmaPkg.sv
// Enigma package with the vector types shared by the machine
`default_nettype none

`include "enigma_cfg.svh"

package enigmaPkg;

    // Character as seen on keyChar and outChar
    typedef logic [`ENIGMA_CHAR_WIDTH-1:0] asciiChar;

    // One active contact per letter, bit 0 is A
    typedef logic [`ENIGMA_LETTERS-1:0] letterOneHot;

    typedef logic [`ENIGMA_POS_WIDTH-1:0] rotorPos;

endpackage

`default_nettype wire

// File: rtl/enigma_cfg.svh
// Enigma configuration constants for the alphabet, character and rotor widths
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

// Letters on the keyboard, one contact each
`define ENIGMA_LETTERS 26

// Width of an ASCII character on the outside ports
`define ENIGMA_CHAR_WIDTH 8

// Enough bits for positions 0 to 25
`define ENIGMA_POS_WIDTH 5

// ASCII code of 'A'
`define ENIGMA_ASCII_A 65

`endif

// File: rtl/letterDecoder.sv
// Letter decoder turning an ASCII code into one active rotor contact
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module letterDecoder (
    input  enigmaPkg::asciiChar    keyChar,
    output enigmaPkg::letterOneHot letter,
    output logic                   isLetter
);

    // One comparator per contact, A to Z only
    always_comb begin
        letter = '0;
        for (int i = 0; i < `ENIGMA_LETTERS; i++) begin
            if (keyChar == enigmaPkg::asciiChar'(`ENIGMA_ASCII_A + i)) begin
                letter[i] = 1'b1;
            end
        end
    end

    // Digits, spaces and lower case leave every contact low
    assign isLetter = |letter;

endmodule

`default_nettype wire

// File: rtl/letterEncoder.sv
// Letter encoder turning the active contact back into its ASCII code
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module letterEncoder (
    input  enigmaPkg::letterOneHot letter,
    output enigmaPkg::asciiChar    encodedChar
);

    // OR of the codes of all active contacts
    // Exactly one is active whenever a letter went in
    always_comb begin
        encodedChar = '0;
        for (int i = 0; i < `ENIGMA_LETTERS; i++) begin
            if (letter[i]) begin
                encodedChar = encodedChar | enigmaPkg::asciiChar'(`ENIGMA_ASCII_A + i);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/plugBoard.sv
// Plugboard permutation with the forward table and its inverse on the way back
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module plugBoard (
    input  enigmaPkg::letterOneHot forwardIn,
    input  enigmaPkg::letterOneHot backwardIn,
    output enigmaPkg::letterOneHot forwardOut,
    output enigmaPkg::letterOneHot backwardOut
);

    // Output contact i is fed from input contact sourceContact[i]
    localparam int sourceContact [`ENIGMA_LETTERS] = '{
        4, 10, 12, 5, 11, 6, 3, 16, 21, 25, 13, 19, 14,
        22, 24, 7, 23, 20, 18, 15, 0, 8, 1, 17, 2, 9
    };

    for (genvar i = 0; i < `ENIGMA_LETTERS; i++) begin : gPlug
        assign forwardOut[i] = forwardIn[sourceContact[i]];
        // Same cable walked the other way
        assign backwardOut[sourceContact[i]] = backwardIn[i];
    end

endmodule

`default_nettype wire

// File: rtl/reflector.sv
// Reflector pairing every contact with another one and sending the signal back
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module reflector (
    input  enigmaPkg::letterOneHot contactsIn,
    output enigmaPkg::letterOneHot contactsOut
);

    // Partner of each contact, pairs are symmetric with no contact on itself
    localparam int partner [`ENIGMA_LETTERS] = '{
        24, 17, 20, 7, 16, 18, 11, 3, 15, 23, 13, 6, 14,
        10, 12, 8, 4, 1, 5, 25, 2, 22, 21, 9, 0, 19
    };

    for (genvar i = 0; i < `ENIGMA_LETTERS; i++) begin : gReflect
        assign contactsOut[i] = contactsIn[partner[i]];
    end

endmodule

`default_nettype wire

// File: rtl/rotorWheel.sv
// Enigma rotor with selectable wiring, a position register, stepping and carry
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module rotorWheel #(
    parameter int rotorType = 1
) (
    input  logic                   load,
    input  logic                   reset,
    input  logic                   setPositions,
    input  logic                   stepIn,
    input  enigmaPkg::rotorPos     startPosition,
    input  enigmaPkg::letterOneHot forwardIn,
    input  enigmaPkg::letterOneHot backwardIn,
    output enigmaPkg::letterOneHot forwardOut,
    output enigmaPkg::letterOneHot backwardOut,
    output logic                   carryOut
);

    // Inner contact i is fed from inner contact wiringTypeN[i]
    localparam int wiringType1 [`ENIGMA_LETTERS] = '{
        7, 12, 21, 17, 0, 2, 22, 20, 23, 18, 9, 25, 15,
        3, 14, 13, 11, 8, 4, 10, 6, 5, 19, 16, 24, 1
    };
    localparam int wiringType2 [`ENIGMA_LETTERS] = '{
        19, 4, 7, 6, 12, 17, 8, 5, 2, 0, 1, 20, 25,
        9, 14, 22, 24, 18, 15, 13, 3, 10, 21, 16, 11, 23
    };
    localparam int wiringType3 [`ENIGMA_LETTERS] = '{
        19, 0, 6, 1, 15, 2, 18, 3, 16, 4, 20, 5, 21,
        13, 25, 7, 24, 8, 23, 9, 22, 11, 17, 10, 14, 12
    };

    enigmaPkg::rotorPos     position;
    enigmaPkg::rotorPos     loadPosition;
    enigmaPkg::letterOneHot innerFwd;
    enigmaPkg::letterOneHot wiredFwd;
    enigmaPkg::letterOneHot innerBack;
    enigmaPkg::letterOneHot wiredBack;

    // Contact c moves to c - amount
    function automatic enigmaPkg::letterOneHot rotateBack(
        input enigmaPkg::letterOneHot contacts,
        input enigmaPkg::rotorPos     amount
    );
        logic [2*`ENIGMA_LETTERS-1:0] doubled;
        logic [2*`ENIGMA_LETTERS-1:0] shifted;
        doubled = {contacts, contacts};
        shifted = doubled >> amount;
        return shifted[`ENIGMA_LETTERS-1:0];
    endfunction

    // Contact c moves to c + amount
    function automatic enigmaPkg::letterOneHot rotateForward(
        input enigmaPkg::letterOneHot contacts,
        input enigmaPkg::rotorPos     amount
    );
        logic [2*`ENIGMA_LETTERS-1:0] doubled;
        logic [2*`ENIGMA_LETTERS-1:0] shifted;
        doubled = {contacts, contacts};
        shifted = doubled >> (`ENIGMA_LETTERS - amount);
        return shifted[`ENIGMA_LETTERS-1:0];
    endfunction

    assign innerFwd   = rotateBack(forwardIn, position);
    assign forwardOut = rotateForward(wiredFwd, position);

    assign innerBack   = rotateBack(backwardIn, position);
    assign backwardOut = rotateForward(wiredBack, position);

    for (genvar i = 0; i < `ENIGMA_LETTERS; i++) begin : gWire
        localparam int src = (rotorType == 2) ? wiringType2[i] :
                             (rotorType == 3) ? wiringType3[i] : wiringType1[i];
        assign wiredFwd[i]   = innerFwd[src];
        // Inverse wiring for the return trip
        assign wiredBack[src] = innerBack[i];
    end

    // Start positions above 25 wrap once
    assign loadPosition = (startPosition >= enigmaPkg::rotorPos'(`ENIGMA_LETTERS)) ?
                          enigmaPkg::rotorPos'(startPosition - `ENIGMA_LETTERS) :
                          startPosition;

    assign carryOut = stepIn && (position == enigmaPkg::rotorPos'(`ENIGMA_LETTERS - 1));

    always_ff @(posedge load) begin
        if (reset) begin
            position <= '0;
        end else if (setPositions) begin
            position <= loadPosition;
        end else if (stepIn) begin
            position <= carryOut ? '0 : position + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Builds the Enigma testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f enigma.f --top-module enigmaTb -Mdir obj_dir -o enigmaSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/enigmaSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation binary returned status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: sim/enigmaModel.svh
// Enigma reference model with its own copy of the wiring tables and odometer stepping
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

// Output contact i of each stage is fed from input contact table[i]
localparam int plugSource [`ENIGMA_LETTERS] = '{
    4, 10, 12, 5, 11, 6, 3, 16, 21, 25, 13, 19, 14,
    22, 24, 7, 23, 20, 18, 15, 0, 8, 1, 17, 2, 9
};
localparam int rotorSource [3][`ENIGMA_LETTERS] = '{
    '{7, 12, 21, 17, 0, 2, 22, 20, 23, 18, 9, 25, 15,
      3, 14, 13, 11, 8, 4, 10, 6, 5, 19, 16, 24, 1},
    '{19, 4, 7, 6, 12, 17, 8, 5, 2, 0, 1, 20, 25,
      9, 14, 22, 24, 18, 15, 13, 3, 10, 21, 16, 11, 23},
    '{19, 0, 6, 1, 15, 2, 18, 3, 16, 4, 20, 5, 21,
      13, 25, 7, 24, 8, 23, 9, 22, 11, 17, 10, 14, 12}
};
localparam int reflectPartner [`ENIGMA_LETTERS] = '{
    24, 17, 20, 7, 16, 18, 11, 3, 15, 23, 13, 6, 14,
    10, 12, 8, 4, 1, 5, 25, 2, 22, 21, 9, 0, 19
};

int modelPos [3];

function automatic bit isLetterKey(input enigmaPkg::asciiChar key);
    int code;
    code = int'(key) - `ENIGMA_ASCII_A;
    return (code >= 0) && (code < `ENIGMA_LETTERS);
endfunction

// Stage 3 is the plugboard, 0 to 2 are the rotors
function automatic int walkForward(input int stage, input int contact);
    int result;
    result = 0;
    for (int i = 0; i < `ENIGMA_LETTERS; i++) begin
        if ((stage == 3 ? plugSource[i] : rotorSource[stage][i]) == contact) begin
            result = i;
        end
    end
    return result;
endfunction

function automatic int shiftContact(input int contact, input int amount);
    return (contact + amount + 2 * `ENIGMA_LETTERS) % `ENIGMA_LETTERS;
endfunction

function automatic enigmaPkg::asciiChar modelCipher(input enigmaPkg::asciiChar key);
    int c;
    if (!isLetterKey(key)) begin
        return key;
    end
    c = walkForward(3, int'(key) - `ENIGMA_ASCII_A);
    for (int r = 0; r < 3; r++) begin
        c = shiftContact(walkForward(r, shiftContact(c, -modelPos[r])), modelPos[r]);
    end
    c = reflectPartner[c];
    for (int r = 2; r >= 0; r--) begin
        c = shiftContact(rotorSource[r][shiftContact(c, -modelPos[r])], modelPos[r]);
    end
    return enigmaPkg::asciiChar'(`ENIGMA_ASCII_A + plugSource[c]);
endfunction

// Odometer, a rotor moves on only when every rotor below it wrapped
function automatic void modelStep(input enigmaPkg::asciiChar key);
    if (isLetterKey(key)) begin
        for (int r = 0; r < 3; r++) begin
            modelPos[r] = (modelPos[r] + 1) % `ENIGMA_LETTERS;
            if (modelPos[r] != 0) begin
                break;
            end
        end
    end
endfunction

function automatic void modelLoad(input int p1, input int p2, input int p3);
    modelPos[0] = p1 % `ENIGMA_LETTERS;
    modelPos[1] = p2 % `ENIGMA_LETTERS;
    modelPos[2] = p3 % `ENIGMA_LETTERS;
endfunction

`endif

// File: sim/enigmaTb.sv
// Enigma testbench running directed tests against the reference model
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module enigmaTb;

    localparam int clkPeriod = 20;
    // Keys over all tests, sizes the watchdog
    localparam int totalKeys = 1 + 40 + 24 + 26 + 6 + 6;

    logic                load;
    logic                reset;
    logic                keyValid;
    logic                setPositions;
    enigmaPkg::asciiChar keyChar;
    enigmaPkg::rotorPos  startPosition1;
    enigmaPkg::rotorPos  startPosition2;
    enigmaPkg::rotorPos  startPosition3;
    logic                outValid;
    enigmaPkg::asciiChar outChar;

    int          errorCount;
    int          checkCount;
    logic [31:0] rngState;

    `include "enigmaModel.svh"

    enigmaMachine dut_i (
        .load           (load),
        .reset          (reset),
        .keyValid       (keyValid),
        .setPositions   (setPositions),
        .keyChar        (keyChar),
        .startPosition1 (startPosition1),
        .startPosition2 (startPosition2),
        .startPosition3 (startPosition3),
        .outValid       (outValid),
        .outChar        (outChar)
    );

    always #(clkPeriod / 2) load = ~load;

    initial begin
        #((totalKeys + 200) * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic enigmaPkg::asciiChar randomLetter();
        rngState = xorshift(rngState);
        return enigmaPkg::asciiChar'(`ENIGMA_ASCII_A + rngState % `ENIGMA_LETTERS);
    endfunction

    // 0 to 31, so some loads need the modulo
    function automatic int randomPosition();
        rngState = xorshift(rngState);
        return int'(rngState[4:0]);
    endfunction

    task automatic compareChar(input string testName, input enigmaPkg::asciiChar expected,
                               input enigmaPkg::asciiChar actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected 0x%02h actual 0x%02h", testName, expected, actual);
        end
    endtask

    task automatic comparePos(input string testName, input enigmaPkg::rotorPos expected,
                              input enigmaPkg::rotorPos actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %0d actual %0d", testName, expected, actual);
        end
    endtask

    task automatic reportTest(input string testName, input int startErrors);
        $display("Test %s finished with %0d errors", testName, errorCount - startErrors);
    endtask

    // A key offered alongside the load must be dropped by the DUT
    task automatic loadPositions(input int p1, input int p2, input int p3);
        @(posedge load);
        setPositions   <= 1'b1;
        keyValid       <= 1'b1;
        keyChar        <= randomLetter();
        startPosition1 <= enigmaPkg::rotorPos'(p1);
        startPosition2 <= enigmaPkg::rotorPos'(p2);
        startPosition3 <= enigmaPkg::rotorPos'(p3);
        @(posedge load);
        setPositions <= 1'b0;
        keyValid     <= 1'b0;
        modelLoad(p1, p2, p3);
        @(negedge load);
        checkCount++;
        if (outValid !== 1'b0) begin
            errorCount++;
            $display("load: key offered together with setPositions was accepted");
        end
    endtask

    task automatic streamKeys(input string testName, input enigmaPkg::asciiChar keys[$],
                              output enigmaPkg::asciiChar results[$]);
        enigmaPkg::asciiChar expected[$];
        int sent;
        int idle;
        results = {};
        sent = 0;
        idle = 0;
        foreach (keys[i]) begin
            expected.push_back(modelCipher(keys[i]));
            modelStep(keys[i]);
        end
        while (results.size() < keys.size() && idle < 4) begin
            @(posedge load);
            keyValid <= (sent < keys.size());
            if (sent < keys.size()) begin
                keyChar <= keys[sent];
                sent++;
            end
            @(negedge load);
            if (outValid) begin
                results.push_back(outChar);
                idle = 0;
            end else begin
                idle++;
            end
        end
        @(posedge load);
        keyValid <= 1'b0;
        @(negedge load);
        checkCount++;
        if (results.size() != keys.size() || outValid) begin
            errorCount++;
            $display("%s: %0d keys sent but %0d single-cycle outputs seen",
                     testName, keys.size(), results.size());
        end
        foreach (results[i]) begin
            compareChar(testName, expected[i], results[i]);
            if (isLetterKey(keys[i])) begin
                checkCount++;
                if (results[i] == keys[i]) begin
                    errorCount++;
                    $display("%s: letter %c came out as itself", testName, keys[i]);
                end
            end
        end
    endtask

    task automatic testReset();
        enigmaPkg::asciiChar keys[$];
        enigmaPkg::asciiChar results[$];
        int startErrors;
        startErrors = errorCount;
        repeat (5) begin
            @(negedge load);
            checkCount++;
            if (outValid !== 1'b0 || outChar !== '0) begin
                errorCount++;
                $display("reset: output active while no key was sent");
            end
        end
        modelLoad(0, 0, 0);
        keys.push_back(randomLetter());
        streamKeys("reset", keys, results);
        reportTest("reset", startErrors);
    endtask

    task automatic testRandomStream();
        enigmaPkg::asciiChar keys[$];
        enigmaPkg::asciiChar results[$];
        int startErrors;
        startErrors = errorCount;
        repeat (40) begin
            keys.push_back(randomLetter());
        end
        streamKeys("random stream", keys, results);
        reportTest("random stream", startErrors);
    endtask

    task automatic testReciprocity();
        enigmaPkg::asciiChar message[$];
        enigmaPkg::asciiChar cipher[$];
        enigmaPkg::asciiChar plain[$];
        int p1;
        int p2;
        int p3;
        int startErrors;
        startErrors = errorCount;
        p1 = randomPosition();
        p2 = randomPosition();
        p3 = randomPosition();
        repeat (12) begin
            message.push_back(randomLetter());
        end
        loadPositions(p1, p2, p3);
        streamKeys("reciprocity", message, cipher);
        loadPositions(p1, p2, p3);
        streamKeys("reciprocity", cipher, plain);
        foreach (message[i]) begin
            compareChar("reciprocity", message[i], plain[i]);
        end
        reportTest("reciprocity", startErrors);
    endtask

    // Whole alphabet, self-mapping is checked inside streamKeys
    task automatic testSelfMapping();
        enigmaPkg::asciiChar keys[$];
        enigmaPkg::asciiChar results[$];
        int startErrors;
        startErrors = errorCount;
        for (int i = 0; i < `ENIGMA_LETTERS; i++) begin
            keys.push_back(enigmaPkg::asciiChar'(`ENIGMA_ASCII_A + i));
        end
        loadPositions(randomPosition(), randomPosition(), randomPosition());
        streamKeys("no self-mapping", keys, results);
        reportTest("no self-mapping", startErrors);
    endtask

    task automatic testCarryChain();
        enigmaPkg::asciiChar keys[$];
        enigmaPkg::asciiChar results[$];
        int startErrors;
        startErrors = errorCount;
        repeat (6) begin
            keys.push_back(randomLetter());
        end
        loadPositions(25, 25, 3);
        streamKeys("carry chain", keys, results);
        // First key wraps rotors 1 and 2 and moves rotor 3 to 4
        comparePos("carry chain", enigmaPkg::rotorPos'(5), enigmaPkg::rotorPos'(modelPos[0]));
        comparePos("carry chain", enigmaPkg::rotorPos'(0), enigmaPkg::rotorPos'(modelPos[1]));
        comparePos("carry chain", enigmaPkg::rotorPos'(4), enigmaPkg::rotorPos'(modelPos[2]));
        reportTest("carry chain", startErrors);
    endtask

    task automatic testNonLetters();
        enigmaPkg::asciiChar keys[$];
        enigmaPkg::asciiChar results[$];
        int startErrors;
        startErrors = errorCount;
        keys.push_back(randomLetter());
        keys.push_back("7");
        keys.push_back(" ");
        keys.push_back(randomLetter());
        keys.push_back("a");
        keys.push_back(randomLetter());
        loadPositions(randomPosition(), randomPosition(), randomPosition());
        streamKeys("non-letters", keys, results);
        reportTest("non-letters", startErrors);
    endtask

    initial begin
        load           = 1'b0;
        reset          = 1'b1;
        keyValid       = 1'b0;
        setPositions   = 1'b0;
        keyChar        = '0;
        startPosition1 = '0;
        startPosition2 = '0;
        startPosition3 = '0;
        errorCount     = 0;
        checkCount     = 0;
        rngState       = 32'hf6cb;
        repeat (8) @(posedge load);
        reset <= 1'b0;
        testReset();
        testRandomStream();
        testReciprocity();
        testSelfMapping();
        testCarryChain();
        testNonLetters();
        $display("Tests: 6, checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
